/* accel_subsys.f */
+incdir+include
design/accel_pkg.sv
design/pkt_mem.sv
design/match_engine.sv
design/accel_wrap.sv
design/accel_subsys.sv
sim/tb_clock_gen.sv
sim/accel_tb.sv

/* Bender.yml */
package:
  name: accel_subsys

sources:
  - include_dirs:
      - include
    files:
      - design/accel_pkg.sv
      - design/pkt_mem.sv
      - design/match_engine.sv
      - design/accel_wrap.sv
      - design/accel_subsys.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_clock_gen.sv
      - sim/accel_tb.sv

/* sim/accel_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "accel_defines.svh"

module accel_tb;
  import accel_pkg::*;

  localparam int POLL_LIMIT    = 1000;
  localparam int CLK_PERIOD_NS = 4;
  // 250 words of a 1000 byte scan, each a fetch, a wait and four byte cycles.
  localparam int LONG_SCAN_CYCLES = 1500;

  logic                  clk;
  logic                  rst;
  logic                  io_en;
  logic                  io_wen;
  logic [`IO_STRB_W-1:0] io_strb;
  io_addr_t              io_addr;
  io_data_t              io_wr_data;
  io_data_t              io_rd_data;
  logic                  io_rd_valid;

  logic [7:0] pkt_bytes [2][1024]; // host copy of both packet memories.
  int         cur_addr [2];
  int         cur_len [2];
  pattern_t   cur_pat [2];
  logic [1:0] exp_match;
  int         checks;
  int         errors;
  int         err_mark;

  tb_clock_gen #(.PERIOD_NS(CLK_PERIOD_NS)) clk_gen (.clk(clk), .rst(rst));

  accel_subsys uut (
    .clk         (clk),
    .rst         (rst),
    .io_en       (io_en),
    .io_wen      (io_wen),
    .io_strb     (io_strb),
    .io_addr     (io_addr),
    .io_wr_data  (io_wr_data),
    .io_rd_data  (io_rd_data),
    .io_rd_valid (io_rd_valid)
  );

  // scanned byte k sits in lane k mod 4 of word start + k / 4, wrapping at 256 words.
  function automatic int byte_index(input int start, input int k);
    return ((start + k / 4) % 256) * 4 + k % 4;
  endfunction

  function automatic logic ref_match(input logic [7:0] pkt [1024], input int start,
                                     input int len, input logic [31:0] pat);
    logic found;
    logic same;
    found = 1'b0;
    for (int i = 0; i + 4 <= len; i++) begin
      same = 1'b1;
      for (int j = 0; j < 4; j++) begin
        if (pkt[byte_index(start, i + j)] != pat[8*j +: 8]) same = 1'b0;
      end
      if (same) found = 1'b1;
    end
    return found;
  endfunction

  function automatic io_addr_t reg_addr(input int e, input int off);
    return io_addr_t'((e << 4) | off);
  endfunction

  function automatic io_addr_t mem_addr(input int e, input int w);
    return io_addr_t'((1 << `MEM_WIN_BIT) | (e << 11) | (w << 2));
  endfunction

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Mismatch at time %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic finish_test(input string name);
    $display("%-24s %s", name, (errors == err_mark) ? "passed" : "failed");
    err_mark = errors;
  endtask

  task automatic bus_write(input io_addr_t addr, input io_data_t data);
    @(posedge clk);
    io_en      <= 1'b1;
    io_wen     <= 1'b1;
    io_strb    <= 4'hf;
    io_addr    <= addr;
    io_wr_data <= data;
    @(posedge clk);
    io_en  <= 1'b0;
    io_wen <= 1'b0;
  endtask

  // the valid pulse is checked on the falling edges around it.
  task automatic bus_read(input io_addr_t addr, output io_data_t data);
    @(posedge clk);
    io_en   <= 1'b1;
    io_wen  <= 1'b0;
    io_addr <= addr;
    @(negedge clk);
    check_eq(32'(io_rd_valid), 32'd0, "read valid before the access is taken");
    @(posedge clk);
    io_en <= 1'b0;
    @(negedge clk);
    check_eq(32'(io_rd_valid), 32'd1, "read valid one cycle after the access");
    data = io_rd_data;
    @(negedge clk);
    check_eq(32'(io_rd_valid), 32'd0, "read valid lasts one cycle");
  endtask

  task automatic mem_write(input int e, input int w);
    io_data_t word;
    for (int b = 0; b < 4; b++) word[8*b +: 8] = pkt_bytes[e][4*w + b];
    bus_write(mem_addr(e, w), word);
  endtask

  // back to back CTRL writes, so two engines start one cycle apart.
  task automatic start_engines(input logic [1:0] mask);
    for (int e = 0; e < 2; e++) begin
      if (mask[e]) begin
        @(posedge clk);
        io_en      <= 1'b1;
        io_wen     <= 1'b1;
        io_strb    <= 4'hf;
        io_addr    <= reg_addr(e, `REG_CTRL);
        io_wr_data <= 32'h1;
      end
    end
    @(posedge clk);
    io_en  <= 1'b0;
    io_wen <= 1'b0;
  endtask

  task automatic prep_scan(input int e, input int len, input logic plant);
    int       sa;
    int       off;
    pattern_t pat;
    sa  = $urandom % 256;
    off = (len >= 4) ? $urandom % (len - 3) : 0;
    pat = ($urandom & 32'h7f7f_7f7f) | 32'h0000_0080; // only byte 0 has bit 7 set.
    for (int k = 0; k < 4 * (len / 4 + 2); k++) begin
      pkt_bytes[e][byte_index(sa, k)] = 8'($urandom & 32'h7f);
    end
    if (plant) begin
      for (int j = 0; j < 4; j++) pkt_bytes[e][byte_index(sa, off + j)] = pat[8*j +: 8];
    end
    for (int w = 0; w < len / 4 + 2; w++) mem_write(e, (sa + w) % 256);
    bus_write(reg_addr(e, `REG_LEN), 32'(len));
    bus_write(reg_addr(e, `REG_ADDR), 32'(sa));
    bus_write(reg_addr(e, `REG_PAT), pat);
    cur_addr[e] = sa;
    cur_len[e]  = len;
    cur_pat[e]  = pat;
  endtask

  task automatic wait_done(input int e);
    io_data_t ctrl;
    int       polls;
    ctrl  = '0;
    polls = 0;
    while (!(ctrl[8] && !ctrl[0]) && polls < POLL_LIMIT) begin
      bus_read(reg_addr(e, `REG_CTRL), ctrl);
      polls++;
    end
    if (!(ctrl[8] && !ctrl[0])) begin
      $display("engine %0d gave no done within %0d status reads", e, POLL_LIMIT);
      errors++;
    end
  endtask

  task automatic check_result(input int e);
    logic [7:0] scan_bytes [1024];
    io_data_t   ctrl;
    for (int i = 0; i < 1024; i++) scan_bytes[i] = pkt_bytes[e][i];
    exp_match[e] = ref_match(scan_bytes, cur_addr[e], cur_len[e], cur_pat[e]);
    bus_read(reg_addr(e, `REG_CTRL), ctrl);
    check_eq(32'(ctrl[8]), 32'd1, $sformatf("engine %0d done", e));
    check_eq(32'(ctrl[9]), 32'(exp_match[e]), $sformatf(
             "engine %0d match, addr %0d len %0d pattern %h", e, cur_addr[e], cur_len[e],
             cur_pat[e]));
  endtask

  task automatic single_scan(input int e, input int len, input logic plant);
    prep_scan(e, len, plant);
    start_engines(2'(1 << e));
    wait_done(e);
    check_result(e);
  endtask

  task automatic run_pair(input logic [1:0] plant);
    io_data_t exp;
    io_data_t got;
    for (int e = 0; e < 2; e++) prep_scan(e, 8 + $urandom % 56, plant[e]);
    start_engines(2'b11);
    for (int e = 0; e < 2; e++) wait_done(e);
    for (int e = 0; e < 2; e++) check_result(e);
    exp       = '0;
    exp[1:0]  = 2'b11;
    exp[9:8]  = exp_match;
    exp[16]   = 1'b1;
    exp[17]   = |exp_match;
    bus_read(io_addr_t'(1 << `GLOBAL_BIT), got);
    check_eq(got, exp, "global status word");
  endtask

  initial begin
    io_data_t rdata;
    io_data_t wdata;
    io_data_t ctrl;
    int       polls;
    time      t_first;
    void'($urandom(32'hf176_1360));
    io_en      <= 1'b0;
    io_wen     <= 1'b0;
    io_strb    <= '0;
    io_addr    <= '0;
    io_wr_data <= '0;
    checks   = 0;
    errors   = 0;
    err_mark = 0;
    for (int i = 0; i < 32 && rst !== 1'b0; i++) @(posedge clk);
    if (rst !== 1'b0) begin
      $display("reset was never released");
      errors++;
    end

    for (int i = 0; i < 8; i++) begin
      @(negedge clk);
      check_eq(32'(io_rd_valid), 32'd0, "read valid idle after reset");
    end
    bus_read(io_addr_t'(1 << `GLOBAL_BIT), rdata);
    check_eq(rdata, 32'h0, "global word after reset");
    for (int e = 0; e < 2; e++) begin
      for (int r = 0; r < 4; r++) begin
        bus_read(reg_addr(e, 4 * r), rdata);
        check_eq(rdata, (r == 0) ? 32'h2 : 32'h0,
                 $sformatf("engine %0d reg %0d after reset", e, r));
      end
    end
    finish_test("reset and read valid");

    for (int e = 0; e < 2; e++) begin
      for (int r = 1; r < 4; r++) begin
        wdata = $urandom;
        if (r == 1) wdata = wdata & 32'hffff; // LEN is 16 bits wide.
        if (r == 2) wdata = wdata & 32'hff; // ADDR is a word address.
        bus_write(reg_addr(e, 4 * r), wdata);
        bus_read(reg_addr(e, 4 * r), rdata);
        check_eq(rdata, wdata, $sformatf("engine %0d reg %0d readback", e, r));
      end
    end
    finish_test("register readback");

    for (int e = 0; e < 2; e++) begin
      for (int w = 0; w < 256; w++) begin
        for (int b = 0; b < 4; b++) pkt_bytes[e][4*w + b] = 8'($urandom & 32'h7f);
        mem_write(e, w);
      end
    end
    repeat (6) run_pair(2'b11);
    finish_test("planted patterns");

    single_scan(0, 8 + $urandom % 56, 1'b0);
    single_scan(1, 3, 1'b1); // pattern sits partly past the end.
    single_scan(0, 0, 1'b1);
    single_scan(1, 0, 1'b0);
    finish_test("no match cases");

    repeat (20) run_pair(2'($urandom));
    finish_test("global status");

    // a long scan keeps engine 0 busy while the next command waits.
    bus_write(reg_addr(0, `REG_LEN), 32'd1000);
    bus_write(reg_addr(0, `REG_ADDR), 32'd0);
    bus_write(reg_addr(0, `REG_PAT), 32'hffff_ffff);
    start_engines(2'b01);
    t_first = $time;
    prep_scan(0, 8 + $urandom % 56, 1'b1);
    start_engines(2'b01);
    ctrl  = 32'h1;
    polls = 0;
    while (ctrl[0] && polls < POLL_LIMIT) begin
      bus_read(reg_addr(0, `REG_CTRL), ctrl);
      if (polls == 0) check_eq(32'(ctrl[0]), 32'd1, "start pending while busy");
      polls++;
    end
    if (ctrl[0]) begin
      $display("engine 0 never took the pending start");
      errors++;
    end
    // the pending start may only be taken once the long scan has ended.
    check_eq(32'(($time - t_first) / CLK_PERIOD_NS >= LONG_SCAN_CYCLES), 32'd1,
             "pending start held until the first scan ended");
    wait_done(0);
    check_result(0);
    finish_test("start while busy");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0; // released on an edge like any other synchronous input.
  end

endmodule

`default_nettype wire

/* design/accel_subsys.sv */
`timescale 1ns/1ps
`default_nettype none

`include "accel_defines.svh"

module accel_subsys (
  input  wire                      clk,
  input  wire                      rst,
  input  wire                      io_en,
  input  wire                      io_wen,
  input  wire [`IO_STRB_W-1:0]     io_strb,
  input  wire accel_pkg::io_addr_t io_addr,
  input  wire accel_pkg::io_data_t io_wr_data,
  output wire accel_pkg::io_data_t io_rd_data,
  output wire                      io_rd_valid
);
  import accel_pkg::*;

  wire mem_addr_t [`ENGINES-1:0] cmd_addr;
  wire byte_len_t [`ENGINES-1:0] cmd_len;
  wire pattern_t [`ENGINES-1:0]  cmd_pattern;
  wire [`ENGINES-1:0]            cmd_valid;
  wire [`ENGINES-1:0]            cmd_ready;
  wire [`ENGINES-1:0]            status_done;
  wire [`ENGINES-1:0]            status_match;

  wire [`ENGINES-1:0]            mem_wr_en;
  wire mem_addr_t                mem_wr_addr;
  wire [`IO_STRB_W-1:0]          mem_wr_strb;
  wire mem_word_t                mem_wr_data;

  wire [`ENGINES-1:0]            rd_en;
  wire mem_addr_t [`ENGINES-1:0] rd_addr;
  wire mem_word_t [`ENGINES-1:0] rd_data;

  accel_wrap u_wrap (
    .clk          (clk),
    .rst          (rst),
    .io_en        (io_en),
    .io_wen       (io_wen),
    .io_strb      (io_strb),
    .io_addr      (io_addr),
    .io_wr_data   (io_wr_data),
    .io_rd_data   (io_rd_data),
    .io_rd_valid  (io_rd_valid),
    .cmd_addr     (cmd_addr),
    .cmd_len      (cmd_len),
    .cmd_pattern  (cmd_pattern),
    .cmd_valid    (cmd_valid),
    .cmd_ready    (cmd_ready),
    .status_done  (status_done),
    .status_match (status_match),
    .mem_wr_en    (mem_wr_en),
    .mem_wr_addr  (mem_wr_addr),
    .mem_wr_strb  (mem_wr_strb),
    .mem_wr_data  (mem_wr_data)
  );

  // each engine owns one packet memory; the host write bus is shared.
  for (genvar g = 0; g < `ENGINES; g++) begin : g_eng
    match_engine u_eng (
      .clk          (clk),
      .rst          (rst),
      .cmd_addr     (cmd_addr[g]),
      .cmd_len      (cmd_len[g]),
      .cmd_pattern  (cmd_pattern[g]),
      .cmd_valid    (cmd_valid[g]),
      .cmd_ready    (cmd_ready[g]),
      .status_done  (status_done[g]),
      .status_match (status_match[g]),
      .rd_en        (rd_en[g]),
      .rd_addr      (rd_addr[g]),
      .rd_data      (rd_data[g])
    );

    pkt_mem u_mem (
      .clk     (clk),
      .rst     (rst),
      .wr_en   (mem_wr_en[g]),
      .wr_addr (mem_wr_addr),
      .wr_strb (mem_wr_strb),
      .wr_data (mem_wr_data),
      .rd_en   (rd_en[g]),
      .rd_addr (rd_addr[g]),
      .rd_data (rd_data[g])
    );
  end

endmodule

`default_nettype wire

/* design/accel_wrap.sv */
`timescale 1ns/1ps
`default_nettype none

`include "accel_defines.svh"

module accel_wrap (
  input  wire                                 clk,
  input  wire                                 rst,
  input  wire                                 io_en,
  input  wire                                 io_wen,
  input  wire [`IO_STRB_W-1:0]                io_strb,
  input  wire accel_pkg::io_addr_t            io_addr,
  input  wire accel_pkg::io_data_t            io_wr_data,
  output accel_pkg::io_data_t                 io_rd_data,
  output logic                                io_rd_valid,
  output accel_pkg::mem_addr_t [`ENGINES-1:0] cmd_addr,
  output accel_pkg::byte_len_t [`ENGINES-1:0] cmd_len,
  output accel_pkg::pattern_t [`ENGINES-1:0]  cmd_pattern,
  output logic [`ENGINES-1:0]                 cmd_valid,
  input  wire [`ENGINES-1:0]                  cmd_ready,
  input  wire [`ENGINES-1:0]                  status_done,
  input  wire [`ENGINES-1:0]                  status_match,
  output logic [`ENGINES-1:0]                 mem_wr_en,
  output accel_pkg::mem_addr_t                mem_wr_addr,
  output logic [`IO_STRB_W-1:0]               mem_wr_strb,
  output accel_pkg::mem_word_t                mem_wr_data
);
  import accel_pkg::*;

  logic     mem_win;
  logic     glob_sel;
  logic     reg_eng;
  logic     mem_eng;
  logic     wr_acc;
  logic     rd_acc;
  logic     reg_wr;
  io_data_t global_word;
  io_data_t rd_mux;

  assign mem_win  = io_addr[`MEM_WIN_BIT];
  assign glob_sel = io_addr[`GLOBAL_BIT];
  assign reg_eng  = io_addr[4];
  assign mem_eng  = io_addr[11];
  assign wr_acc   = io_en && io_wen;
  assign rd_acc   = io_en && !io_wen;
  assign reg_wr   = wr_acc && !mem_win && !glob_sel;

  always_comb begin
    global_word                = '0;
    global_word[`ENGINES-1:0]  = status_done;
    global_word[8 +: `ENGINES] = status_match;
    global_word[16]            = &status_done;
    global_word[17]            = |status_match;
  end

  always_comb begin
    rd_mux = '0; // the memory window reads as zero.
    if (!mem_win) begin
      if (glob_sel) begin
        rd_mux = global_word;
      end else begin
        case ({io_addr[3:2], 2'b00})
          `REG_CTRL: begin
            rd_mux[0] = cmd_valid[reg_eng];
            rd_mux[1] = cmd_ready[reg_eng];
            rd_mux[8] = status_done[reg_eng];
            rd_mux[9] = status_match[reg_eng];
          end
          `REG_LEN:  rd_mux = io_data_t'(cmd_len[reg_eng]);
          `REG_ADDR: rd_mux = io_data_t'(cmd_addr[reg_eng]);
          `REG_PAT:  rd_mux = cmd_pattern[reg_eng];
          default:   rd_mux = '0;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_valid   <= '0;
      cmd_addr    <= '0;
      cmd_len     <= '0;
      cmd_pattern <= '0;
      io_rd_valid <= 1'b0;
      mem_wr_en   <= '0;
    end else begin
      cmd_valid   <= cmd_valid & ~cmd_ready; // drops the clock after the handshake.
      io_rd_valid <= rd_acc;
      mem_wr_en   <= '0;
      if (wr_acc && mem_win) mem_wr_en[mem_eng] <= 1'b1;
      if (reg_wr) begin
        case ({io_addr[3:2], 2'b00})
          `REG_CTRL: begin
            if (io_strb[0] && io_wr_data[0]) cmd_valid[reg_eng] <= 1'b1;
          end
          `REG_LEN: begin
            for (int b = 0; b < 2; b++) begin
              if (io_strb[b]) cmd_len[reg_eng][8*b +: 8] <= io_wr_data[8*b +: 8];
            end
          end
          `REG_ADDR: begin
            if (io_strb[0]) cmd_addr[reg_eng] <= io_wr_data[`MEM_ADDR_W-1:0];
          end
          `REG_PAT: begin
            for (int b = 0; b < `IO_STRB_W; b++) begin
              if (io_strb[b]) cmd_pattern[reg_eng][8*b +: 8] <= io_wr_data[8*b +: 8];
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_acc && mem_win) begin
      mem_wr_addr <= io_addr[9:2];
      mem_wr_strb <= io_strb;
      mem_wr_data <= io_wr_data;
    end
    if (rd_acc) io_rd_data <= rd_mux;
  end

endmodule

`default_nettype wire

/* design/match_engine.sv */
`timescale 1ns/1ps
`default_nettype none

`include "accel_defines.svh"

module match_engine (
  input  wire                       clk,
  input  wire                       rst,
  input  wire accel_pkg::mem_addr_t cmd_addr,
  input  wire accel_pkg::byte_len_t cmd_len,
  input  wire accel_pkg::pattern_t  cmd_pattern,
  input  wire                       cmd_valid,
  output logic                      cmd_ready,
  output logic                      status_done,
  output logic                      status_match,
  output logic                      rd_en,
  output accel_pkg::mem_addr_t      rd_addr,
  input  wire accel_pkg::mem_word_t rd_data
);
  import accel_pkg::*;

  eng_state_t  state;
  mem_addr_t   word_addr;
  byte_len_t   len;
  byte_len_t   byte_cnt;
  byte_len_t   cnt_next;
  pattern_t    pattern;
  mem_word_t   word_buf;
  logic [23:0] hist;
  logic [7:0]  cur_byte;
  logic        hit;
  logic        accept;

  assign cmd_ready = (state == ST_IDLE);
  assign accept    = cmd_ready && cmd_valid;

  assign rd_en   = (state == ST_FETCH);
  assign rd_addr = word_addr;

  assign cur_byte = word_buf[8*byte_cnt[1:0] +: 8];
  assign cnt_next = byte_cnt + 1'b1;

  // hist holds the three previous bytes, oldest in the low lane, so the
  // window lines up with pattern byte 0 first.
  assign hit = (byte_cnt >= byte_len_t'(3)) && ({cur_byte, hist} == pattern);

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= ST_IDLE;
      status_done  <= 1'b0;
      status_match <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (accept) begin
            status_done  <= 1'b0;
            status_match <= 1'b0;
            state        <= (cmd_len == '0) ? ST_FINISH : ST_FETCH;
          end
        end
        ST_FETCH: begin
          state <= ST_WAIT_WORD;
        end
        ST_WAIT_WORD: begin
          state <= ST_SCAN; // word is latched on the way out.
        end
        ST_SCAN: begin
          if (hit) begin
            status_match <= 1'b1;
            state        <= ST_FINISH;
          end else if (cnt_next == len) begin
            state <= ST_FINISH;
          end else if (byte_cnt[1:0] == 2'd3) begin
            state <= ST_FETCH; // last byte of this word.
          end
        end
        ST_FINISH: begin
          status_done <= 1'b1;
          state       <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      word_addr <= cmd_addr;
      len       <= cmd_len;
      pattern   <= cmd_pattern;
      byte_cnt  <= '0;
    end

    if (state == ST_WAIT_WORD) begin
      word_buf  <= rd_data;
      word_addr <= word_addr + 1'b1;
    end

    // the history carries across words, so matches over a boundary are seen.
    if (state == ST_SCAN) begin
      hist     <= {cur_byte, hist[23:8]};
      byte_cnt <= cnt_next;
    end
  end

endmodule

`default_nettype wire

/* design/pkt_mem.sv */
`timescale 1ns/1ps
`default_nettype none

`include "accel_defines.svh"

module pkt_mem (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       wr_en,
  input  wire accel_pkg::mem_addr_t wr_addr,
  input  wire [`IO_STRB_W-1:0]      wr_strb,
  input  wire accel_pkg::mem_word_t wr_data,
  input  wire                       rd_en,
  input  wire accel_pkg::mem_addr_t rd_addr,
  output accel_pkg::mem_word_t      rd_data
);
  import accel_pkg::*;

  mem_word_t mem [`MEM_DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < `IO_STRB_W; b++) begin
        if (wr_strb[b]) mem[wr_addr][8*b +: 8] <= wr_data[8*b +: 8];
      end
    end
  end

  // read port has one cycle of latency and holds its word between reads.
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_data <= '0;
    end else if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

/* design/accel_pkg.sv */
`default_nettype none

`include "accel_defines.svh"

package accel_pkg;

  typedef logic [`IO_DATA_W-1:0]  io_data_t;
  typedef logic [`IO_ADDR_W-1:0]  io_addr_t;
  typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;
  typedef logic [31:0]            mem_word_t; // four bytes, byte 0 in the low lane.
  typedef logic [`LEN_W-1:0]      byte_len_t;
  typedef logic [31:0]            pattern_t;  // byte 0 is matched first.

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_WAIT_WORD,
    ST_SCAN,
    ST_FINISH
  } eng_state_t;

endpackage

`default_nettype wire

/* include/accel_defines.svh */
`ifndef ACCEL_DEFINES_SVH
`define ACCEL_DEFINES_SVH

// host bus widths.
`define IO_DATA_W 32
`define IO_ADDR_W 16
`define IO_STRB_W 4

// packet memory geometry, in 32-bit words.
`define MEM_ADDR_W 8
`define MEM_DEPTH  256

`define LEN_W   16
`define ENGINES 2

// per-engine register offsets.
`define REG_CTRL 4'h0
`define REG_LEN  4'h4
`define REG_ADDR 4'h8
`define REG_PAT  4'hc

`define MEM_WIN_BIT 12
`define GLOBAL_BIT  7

`endif
